// ==== neocore_params.svh ====
// Width, register file, reset vector and PC step macros for the NeoCore core
`ifndef NEOCORE_PARAMS_SVH
`define NEOCORE_PARAMS_SVH

// Data path word width
`define NEO_XLEN 16

// Address and PC width
`define NEO_AWIDTH 32

// Fixed instruction word width
`define NEO_IWIDTH 32

// Register file size and index width
`define NEO_NREGS 16
`define NEO_RWIDTH 4

// First fetch address after reset
`define NEO_RESET_PC 32'h0000_0000

// Byte distance between instruction words
`define NEO_PC_STEP 4

`endif

// ==== neocore_pkg.sv ====
// Opcode, ALU function and fetch state enums, and the pipeline stage records
`default_nettype none
`include "neocore_params.svh"

package neocore_pkg;

  typedef enum logic [7:0] {
    OP_NOP  = 8'h00,
    OP_ADD  = 8'h01,
    OP_SUB  = 8'h02,
    OP_AND  = 8'h03,
    OP_OR   = 8'h04,
    OP_XOR  = 8'h05,
    OP_MOVI = 8'h10,
    OP_LD   = 8'h20,
    OP_ST   = 8'h21,
    OP_BEQ  = 8'h30,
    OP_BNE  = 8'h31,
    OP_BVS  = 8'h32,
    OP_JMP  = 8'h33,
    OP_HLT  = 8'hff
  } opcode_e;

  // PASS hands the immediate through
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS
  } alu_op_e;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_WAIT,
    FS_DROP
  } fetch_state_e;

  // ========================================
  // Stage records
  // ========================================

  typedef struct packed {
    logic                   valid;
    logic [`NEO_AWIDTH-1:0] pc;
    logic [`NEO_IWIDTH-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic                   valid;
    logic [`NEO_AWIDTH-1:0] pc;
    opcode_e                opcode;
    alu_op_e                alu_op;
    logic [`NEO_RWIDTH-1:0] rs1;
    logic [`NEO_RWIDTH-1:0] rs2;
    logic [`NEO_XLEN-1:0]   rs1_val;
    logic [`NEO_XLEN-1:0]   rs2_val;
    logic [`NEO_XLEN-1:0]   imm;
    logic [`NEO_RWIDTH-1:0] rd;
    logic                   rd_we;
    logic                   mem_read;
    logic                   mem_write;
    logic                   is_branch;
    logic                   is_halt;
  } id_ex_t;

  typedef struct packed {
    logic                   valid;
    logic [`NEO_AWIDTH-1:0] pc;
    logic [`NEO_XLEN-1:0]   result;
    logic [`NEO_XLEN-1:0]   store_data;
    logic [`NEO_RWIDTH-1:0] rd;
    logic                   rd_we;
    logic                   mem_read;
    logic                   mem_write;
    logic                   is_halt;
  } ex_mem_t;

  typedef struct packed {
    logic                   valid;
    logic [`NEO_AWIDTH-1:0] pc;
    logic [`NEO_XLEN-1:0]   wb_data;
    logic [`NEO_RWIDTH-1:0] rd;
    logic                   rd_we;
    logic                   is_halt;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== fetch_unit.sv ====
// Fetch unit with PC sequencing, instruction port FSM, reply buffer and IF/ID register
`timescale 1ns/10ps
`default_nettype none
`include "neocore_params.svh"

module fetch_unit
  import neocore_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   redirect,
  input  logic [`NEO_AWIDTH-1:0] redirect_pc,
  input  logic                   id_hold,
  input  logic                   mem_busy,
  input  logic                   halted,
  output logic [`NEO_AWIDTH-1:0] if_addr,
  output logic                   if_req,
  input  logic [`NEO_IWIDTH-1:0] if_rdata,
  input  logic                   if_ack,
  output if_id_t                 if_id,
  output logic [`NEO_AWIDTH-1:0] fetch_pc
);

  fetch_state_e           state_q;
  logic [`NEO_AWIDTH-1:0] pc_q;
  logic [`NEO_AWIDTH-1:0] req_addr_q;
  if_id_t                 if_id_q;
  if_id_t                 pend_q;
  logic                   stall;
  logic                   can_start;
  logic                   ack_take;

  assign stall     = id_hold | mem_busy;
  // One outstanding request, and none while a reply sits in the buffer
  assign can_start = !halted && !stall && !pend_q.valid && !redirect;
  assign ack_take  = (state_q == FS_WAIT) && if_ack && !redirect;

  assign if_req   = (state_q != FS_IDLE);
  assign if_addr  = req_addr_q;
  assign if_id    = if_id_q;
  assign fetch_pc = pc_q;

  // ========================================
  // Request FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FS_IDLE;
      pc_q    <= `NEO_RESET_PC;
    end else begin
      case (state_q)
        FS_IDLE: begin
          if (redirect) begin
            pc_q <= redirect_pc;
          end else if (can_start) begin
            req_addr_q <= pc_q;
            pc_q       <= pc_q + `NEO_AWIDTH'(`NEO_PC_STEP);
            state_q    <= FS_WAIT;
          end
        end
        FS_WAIT: begin
          if (redirect) begin
            pc_q    <= redirect_pc;
            // Reply still owed, so swallow it in DROP
            state_q <= if_ack ? FS_IDLE : FS_DROP;
          end else if (if_ack) begin
            state_q <= FS_IDLE;
          end
        end
        FS_DROP: begin
          if (redirect) begin
            pc_q <= redirect_pc;
          end
          if (if_ack) begin
            state_q <= FS_IDLE;
          end
        end
        default: state_q <= FS_IDLE;
      endcase
    end
  end

  // IF/ID register, replies that land during a hold wait in pend_q
  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      if_id_q.valid <= 1'b0;
      pend_q.valid  <= 1'b0;
    end else if (stall) begin
      if (ack_take) begin
        pend_q <= '{valid: 1'b1, pc: req_addr_q, instr: if_rdata};
      end
    end else if (pend_q.valid) begin
      if_id_q      <= pend_q;
      pend_q.valid <= 1'b0;
    end else if (ack_take) begin
      if_id_q <= '{valid: 1'b1, pc: req_addr_q, instr: if_rdata};
    end else begin
      if_id_q.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== decode_unit.sv ====
// Decode unit with field split, control decode, register file, load-use and halt hold
`timescale 1ns/10ps
`default_nettype none
`include "neocore_params.svh"

module decode_unit
  import neocore_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  if_id_t  if_id,
  input  mem_wb_t wb,
  input  logic    redirect,
  input  logic    mem_busy,
  output logic    id_hold,
  output id_ex_t  id_ex
);

  opcode_e                op;
  logic [`NEO_RWIDTH-1:0] rd;
  logic [`NEO_RWIDTH-1:0] rs1;
  logic [`NEO_RWIDTH-1:0] src_b;
  logic [`NEO_XLEN-1:0]   imm;
  alu_op_e                alu_op;
  logic                   rd_we;
  logic                   mem_read;
  logic                   mem_write;
  logic                   is_branch;
  logic                   is_halt;
  logic                   use_rs1;
  logic                   use_rs2;
  logic [`NEO_XLEN-1:0]   regs [`NEO_NREGS];
  logic [`NEO_XLEN-1:0]   rs1_val;
  logic [`NEO_XLEN-1:0]   rs2_val;
  logic                   wb_write;
  logic                   load_use;
  logic                   halt_pend_q;
  id_ex_t                 id_ex_q;

  assign op    = opcode_e'(if_id.instr[31:24]);
  assign rd    = if_id.instr[23:20];
  assign rs1   = if_id.instr[19:16];
  assign imm   = if_id.instr[15:0];
  // ST reads its data register through the second source
  assign src_b = (op == OP_ST) ? rd : if_id.instr[15:12];

  always_comb begin
    alu_op    = ALU_PASS;
    rd_we     = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_branch = 1'b0;
    is_halt   = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    case (op)
      OP_ADD:  alu_op = ALU_ADD;
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_XOR:  alu_op = ALU_XOR;
      OP_MOVI: rd_we = 1'b1;
      OP_LD: begin
        rd_we    = 1'b1;
        mem_read = 1'b1;
      end
      OP_ST: begin
        mem_write = 1'b1;
        use_rs2   = 1'b1;
      end
      OP_BEQ, OP_BNE, OP_BVS, OP_JMP: is_branch = 1'b1;
      OP_HLT:  is_halt = 1'b1;
      default: ;
    endcase
    if (alu_op != ALU_PASS) begin
      rd_we   = 1'b1;
      use_rs1 = 1'b1;
      use_rs2 = 1'b1;
    end
  end

  // ========================================
  // Register file, write-through on read
  // ========================================
  assign wb_write = wb.valid && wb.rd_we;
  assign rs1_val  = (wb_write && wb.rd == rs1) ? wb.wb_data : regs[rs1];
  assign rs2_val  = (wb_write && wb.rd == src_b) ? wb.wb_data : regs[src_b];

  always_ff @(posedge clk) begin
    if (wb_write) begin
      regs[wb.rd] <= wb.wb_data;
    end
  end

  // Load result not ready until it reaches MEM/WB
  assign load_use = if_id.valid && id_ex_q.valid && id_ex_q.mem_read &&
                    ((use_rs1 && rs1 == id_ex_q.rd) || (use_rs2 && src_b == id_ex_q.rd));
  assign id_hold  = load_use || halt_pend_q;
  assign id_ex    = id_ex_q;

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      id_ex_q.valid <= 1'b0;
      halt_pend_q   <= 1'b0;
    end else if (mem_busy) begin
      // Held record picks up retiring writes it would otherwise miss
      if (wb_write && wb.rd == id_ex_q.rs1) id_ex_q.rs1_val <= wb.wb_data;
      if (wb_write && wb.rd == id_ex_q.rs2) id_ex_q.rs2_val <= wb.wb_data;
    end else if (!if_id.valid || load_use || halt_pend_q) begin
      id_ex_q.valid <= 1'b0;
    end else begin
      id_ex_q <= '{valid: 1'b1, pc: if_id.pc, opcode: op, alu_op: alu_op,
                   rs1: rs1, rs2: src_b, rs1_val: rs1_val, rs2_val: rs2_val,
                   imm: imm, rd: rd, rd_we: rd_we, mem_read: mem_read,
                   mem_write: mem_write, is_branch: is_branch, is_halt: is_halt};
      if (is_halt) halt_pend_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
// Execute stage with operand forwarding, ALU, Z/V flags, branch resolution and EX/MEM
`timescale 1ns/10ps
`default_nettype none
`include "neocore_params.svh"

module execute_stage
  import neocore_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  id_ex_t                 id_ex,
  input  logic                   mem_busy,
  input  mem_wb_t                wb,
  output ex_mem_t                ex_mem,
  output logic                   redirect,
  output logic [`NEO_AWIDTH-1:0] redirect_pc
);

  logic [`NEO_XLEN-1:0] op_a;
  logic [`NEO_XLEN-1:0] op_b;
  logic [`NEO_XLEN-1:0] alu_res;
  logic                 v_next;
  logic                 z_q;
  logic                 v_q;
  logic                 flag_we;
  logic                 cond;
  ex_mem_t              ex_mem_q;

  // Youngest producer wins, loads in EX/MEM are never picked
  function automatic logic [`NEO_XLEN-1:0] fwd_sel(
    input logic [`NEO_RWIDTH-1:0] idx,
    input logic [`NEO_XLEN-1:0]   rf_val,
    input ex_mem_t                em,
    input mem_wb_t                mw
  );
    logic [`NEO_XLEN-1:0] val;
    val = rf_val;
    if (em.valid && em.rd_we && !em.mem_read && em.rd == idx) begin
      val = em.result;
    end else if (mw.valid && mw.rd_we && mw.rd == idx) begin
      val = mw.wb_data;
    end
    return val;
  endfunction

  assign op_a = fwd_sel(id_ex.rs1, id_ex.rs1_val, ex_mem_q, wb);
  assign op_b = fwd_sel(id_ex.rs2, id_ex.rs2_val, ex_mem_q, wb);

  // ========================================
  // ALU and flags
  // ========================================
  always_comb begin
    v_next = 1'b0;
    case (id_ex.alu_op)
      ALU_ADD: begin
        alu_res = op_a + op_b;
        v_next  = (op_a[`NEO_XLEN-1] == op_b[`NEO_XLEN-1]) &&
                  (alu_res[`NEO_XLEN-1] != op_a[`NEO_XLEN-1]);
      end
      ALU_SUB: begin
        alu_res = op_a - op_b;
        v_next  = (op_a[`NEO_XLEN-1] != op_b[`NEO_XLEN-1]) &&
                  (alu_res[`NEO_XLEN-1] != op_a[`NEO_XLEN-1]);
      end
      ALU_AND: alu_res = op_a & op_b;
      ALU_OR:  alu_res = op_a | op_b;
      ALU_XOR: alu_res = op_a ^ op_b;
      default: alu_res = id_ex.imm;
    endcase
  end

  assign flag_we = id_ex.valid && !mem_busy && (id_ex.alu_op != ALU_PASS);

  always_ff @(posedge clk) begin
    if (rst) begin
      z_q <= 1'b0;
      v_q <= 1'b0;
    end else if (flag_we) begin
      z_q <= (alu_res == '0);
      v_q <= v_next;
    end
  end

  // Branch condition from flags left by older instructions
  always_comb begin
    case (id_ex.opcode)
      OP_BEQ:  cond = z_q;
      OP_BNE:  cond = !z_q;
      OP_BVS:  cond = v_q;
      OP_JMP:  cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  assign redirect    = id_ex.valid && id_ex.is_branch && cond && !mem_busy;
  assign redirect_pc = {{(`NEO_AWIDTH - `NEO_XLEN){1'b0}}, id_ex.imm};
  assign ex_mem      = ex_mem_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem_q.valid <= 1'b0;
    end else if (!mem_busy) begin
      ex_mem_q <= '{valid: id_ex.valid, pc: id_ex.pc, result: alu_res, store_data: op_b,
                    rd: id_ex.rd, rd_we: id_ex.rd_we, mem_read: id_ex.mem_read,
                    mem_write: id_ex.mem_write, is_halt: id_ex.is_halt};
    end
  end

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
// Memory stage with data port handshake, write-back select, MEM/WB register and halt latch
`timescale 1ns/10ps
`default_nettype none
`include "neocore_params.svh"

module memory_stage
  import neocore_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  ex_mem_t                ex_mem,
  output logic [`NEO_AWIDTH-1:0] dm_addr,
  output logic [`NEO_XLEN-1:0]   dm_wdata,
  output logic                   dm_we,
  output logic                   dm_req,
  input  logic [`NEO_XLEN-1:0]   dm_rdata,
  input  logic                   dm_ack,
  output logic                   mem_busy,
  output mem_wb_t                mem_wb,
  output logic                   halted,
  output logic [`NEO_AWIDTH-1:0] halt_pc
);

  logic [`NEO_XLEN-1:0]   wb_data;
  mem_wb_t                mem_wb_q;
  logic                   halted_q;
  logic [`NEO_AWIDTH-1:0] halt_pc_q;
  logic                   hlt_retire;

  // ========================================
  // Data port
  // ========================================
  // EX/MEM holds while busy, so address and data stay put until ack
  assign dm_req   = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);
  assign dm_addr  = {{(`NEO_AWIDTH - `NEO_XLEN){1'b0}}, ex_mem.result};
  assign dm_wdata = ex_mem.store_data;
  assign dm_we    = dm_req && ex_mem.mem_write;
  assign mem_busy = dm_req && !dm_ack;

  // Port returns the addressed big-endian halfword as is
  assign wb_data = ex_mem.mem_read ? dm_rdata : ex_mem.result;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_q.valid <= 1'b0;
    end else if (mem_busy) begin
      mem_wb_q.valid <= 1'b0;
    end else begin
      mem_wb_q <= '{valid: ex_mem.valid, pc: ex_mem.pc, wb_data: wb_data,
                    rd: ex_mem.rd, rd_we: ex_mem.rd_we, is_halt: ex_mem.is_halt};
    end
  end

  // ========================================
  // Halt latch
  // ========================================
  assign hlt_retire = mem_wb_q.valid && mem_wb_q.is_halt;

  always_ff @(posedge clk) begin
    if (rst) begin
      halted_q <= 1'b0;
    end else if (hlt_retire) begin
      halted_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (hlt_retire && !halted_q) begin
      halt_pc_q <= mem_wb_q.pc;
    end
  end

  assign mem_wb  = mem_wb_q;
  assign halted  = halted_q;
  assign halt_pc = halt_pc_q;

endmodule

`default_nettype wire

// ==== core_top.sv ====
// NeoCore top level with the four pipeline stages and the external memory ports
`timescale 1ns/10ps
`default_nettype none
`include "neocore_params.svh"

module core_top
  import neocore_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // Instruction fetch port
  output logic [`NEO_AWIDTH-1:0] mem_if_addr,
  output logic                   mem_if_req,
  input  logic [`NEO_IWIDTH-1:0] mem_if_rdata,
  input  logic                   mem_if_ack,
  // Data port, 16-bit big-endian
  output logic [`NEO_AWIDTH-1:0] mem_data_addr,
  output logic [`NEO_XLEN-1:0]   mem_data_wdata,
  output logic                   mem_data_we,
  output logic                   mem_data_req,
  input  logic [`NEO_XLEN-1:0]   mem_data_rdata,
  input  logic                   mem_data_ack,
  // Status
  output logic                   halted,
  output logic [`NEO_AWIDTH-1:0] current_pc
);

  if_id_t                 if_id;
  id_ex_t                 id_ex;
  ex_mem_t                ex_mem;
  mem_wb_t                mem_wb;
  logic                   redirect;
  logic [`NEO_AWIDTH-1:0] redirect_pc;
  logic                   id_hold;
  logic                   mem_busy;
  logic [`NEO_AWIDTH-1:0] fetch_pc;
  logic [`NEO_AWIDTH-1:0] halt_pc;

  // ========================================
  // Pipeline stages
  // ========================================
  fetch_unit u_fetch (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .id_hold     (id_hold),
    .mem_busy    (mem_busy),
    .halted      (halted),
    .if_addr     (mem_if_addr),
    .if_req      (mem_if_req),
    .if_rdata    (mem_if_rdata),
    .if_ack      (mem_if_ack),
    .if_id       (if_id),
    .fetch_pc    (fetch_pc)
  );

  decode_unit u_decode (
    .clk      (clk),
    .rst      (rst),
    .if_id    (if_id),
    .wb       (mem_wb),
    .redirect (redirect),
    .mem_busy (mem_busy),
    .id_hold  (id_hold),
    .id_ex    (id_ex)
  );

  execute_stage u_execute (
    .clk         (clk),
    .rst         (rst),
    .id_ex       (id_ex),
    .mem_busy    (mem_busy),
    .wb          (mem_wb),
    .ex_mem      (ex_mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  memory_stage u_memory (
    .clk      (clk),
    .rst      (rst),
    .ex_mem   (ex_mem),
    .dm_addr  (mem_data_addr),
    .dm_wdata (mem_data_wdata),
    .dm_we    (mem_data_we),
    .dm_req   (mem_data_req),
    .dm_rdata (mem_data_rdata),
    .dm_ack   (mem_data_ack),
    .mem_busy (mem_busy),
    .mem_wb   (mem_wb),
    .halted   (halted),
    .halt_pc  (halt_pc)
  );

  // Once halted, report where the program stopped
  assign current_pc = halted ? halt_pc : fetch_pc;

endmodule

`default_nettype wire

// ==== core_top_sva.sv ====
// Handshake stability, reset and halt assertions, bound to the core top level
`timescale 1ns/10ps
`default_nettype none
`include "neocore_params.svh"

module core_top_sva (
  input logic                   clk,
  input logic                   rst,
  input logic [`NEO_AWIDTH-1:0] mem_if_addr,
  input logic                   mem_if_req,
  input logic                   mem_if_ack,
  input logic [`NEO_AWIDTH-1:0] mem_data_addr,
  input logic [`NEO_XLEN-1:0]   mem_data_wdata,
  input logic                   mem_data_we,
  input logic                   mem_data_req,
  input logic                   mem_data_ack,
  input logic                   halted,
  input logic [`NEO_AWIDTH-1:0] current_pc
);

  int fail_count = 0;

  // ========================================
  // Handshakes
  // ========================================
  if_hold: assert property (@(posedge clk) disable iff (rst)
    mem_if_req && !mem_if_ack |=> mem_if_req && $stable(mem_if_addr))
  else begin
    fail_count++;
    $error("Fetch request dropped or address changed before ack");
  end

  data_hold: assert property (@(posedge clk) disable iff (rst)
    mem_data_req && !mem_data_ack |=> mem_data_req && $stable(mem_data_addr) &&
                                      $stable(mem_data_wdata) && $stable(mem_data_we))
  else begin
    fail_count++;
    $error("Data request dropped or payload changed before ack");
  end

  reset_idle: assert property (@(posedge clk)
    rst |=> !mem_if_req && !mem_data_req && !halted)
  else begin
    fail_count++;
    $error("Port request or halted high after a reset cycle");
  end

  // ========================================
  // Halt
  // ========================================
  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted && $stable(current_pc))
  else begin
    fail_count++;
    $error("Halted dropped or current_pc moved after halt");
  end

  halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halted |-> !$rose(mem_if_req) && !$rose(mem_data_req))
  else begin
    fail_count++;
    $error("New memory request raised after halt");
  end

endmodule

bind core_top core_top_sva u_sva (
  .clk            (clk),
  .rst            (rst),
  .mem_if_addr    (mem_if_addr),
  .mem_if_req     (mem_if_req),
  .mem_if_ack     (mem_if_ack),
  .mem_data_addr  (mem_data_addr),
  .mem_data_wdata (mem_data_wdata),
  .mem_data_we    (mem_data_we),
  .mem_data_req   (mem_data_req),
  .mem_data_ack   (mem_data_ack),
  .halted         (halted),
  .current_pc     (current_pc)
);

`default_nettype wire

// ==== core_top_tb.sv ====
// Testbench for core_top with clock, reset, memory model, program generator and golden model
`timescale 1ns/10ps
`default_nettype none
`include "neocore_params.svh"

module core_top_tb
  import neocore_pkg::*;
();

  localparam int MEM_WORDS = 1024;

  logic                   clk;
  logic                   rst;
  logic [`NEO_AWIDTH-1:0] mem_if_addr;
  logic                   mem_if_req;
  logic [`NEO_IWIDTH-1:0] mem_if_rdata;
  logic                   mem_if_ack;
  logic [`NEO_AWIDTH-1:0] mem_data_addr;
  logic [`NEO_XLEN-1:0]   mem_data_wdata;
  logic                   mem_data_we;
  logic                   mem_data_req;
  logic [`NEO_XLEN-1:0]   mem_data_rdata;
  logic                   mem_data_ack;
  logic                   halted;
  logic [`NEO_AWIDTH-1:0] current_pc;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] gmem [MEM_WORDS];
  logic [31:0] lfsr;
  logic [31:0] exp_addr [$];
  logic [15:0] exp_data [$];
  logic [31:0] hlt_addr;
  logic [7:0]  alu_ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
  int          prog_len;
  int          n_expected;
  int          n_stores;
  int          errors;
  int          cycles;
  int          cycle_limit;
  int          if_cnt;
  int          if_dly;
  int          dm_cnt;
  int          dm_dly;
  logic        rst_q;
  logic        first_fetch_seen;

  always #2 clk = ~clk;

  core_top UUT (
    .clk            (clk),
    .rst            (rst),
    .mem_if_addr    (mem_if_addr),
    .mem_if_req     (mem_if_req),
    .mem_if_rdata   (mem_if_rdata),
    .mem_if_ack     (mem_if_ack),
    .mem_data_addr  (mem_data_addr),
    .mem_data_wdata (mem_data_wdata),
    .mem_data_we    (mem_data_we),
    .mem_data_req   (mem_data_req),
    .mem_data_rdata (mem_data_rdata),
    .mem_data_ack   (mem_data_ack),
    .halted         (halted),
    .current_pc     (current_pc)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hb4bc_d35c) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic int ack_delay();
    int d;
    d = int'(rand_bits(2));
    return (d == 0) ? 1 : d;
  endfunction

  function automatic logic [3:0] src_reg();
    return 4'(1 + rand_bits(3));
  endfunction

  task automatic emit(input logic [7:0] op, input logic [3:0] rd, input logic [3:0] rs1,
                      input logic [15:0] low);
    mem[prog_len] = {op, rd, rs1, low};
    prog_len++;
  endtask

  // ========================================
  // Program generator
  // ========================================
  task automatic build_program();
    logic [15:0] st_addr;
    logic [15:0] ld_addr;
    logic [3:0]  s1;
    logic [3:0]  s2;
    logic [7:0]  br;
    st_addr = 16'h0400;
    for (int r = 1; r <= 8; r++) begin
      emit(OP_MOVI, 4'(r), 4'h0, 16'(rand_bits(16)));
    end
    for (int k = 0; k < 6; k++) begin
      s1 = src_reg();
      s2 = src_reg();
      emit(alu_ops[rand_bits(3) % 5], 4'd9, s1, {s2, 12'h0});
      // Odd blocks force Z and block 2 forces signed overflow
      if (k % 2 == 1) begin
        emit(OP_SUB, 4'd10, 4'd9, {4'd9, 12'h0});
      end else if (k == 2) begin
        emit(OP_MOVI, 4'd13, 4'h0, 16'h4000);
        emit(OP_ADD, 4'd10, 4'd13, {4'd13, 12'h0});
      end else begin
        s2 = src_reg();
        emit(alu_ops[rand_bits(3) % 5], 4'd10, 4'd9, {s2, 12'h0});
      end
      ld_addr = st_addr;
      emit(OP_ST, 4'd10, 4'h0, st_addr);
      st_addr += 2;
      br = (k % 3 == 0) ? OP_BEQ : (k % 3 == 1) ? OP_BNE : OP_BVS;
      emit(br, 4'h0, 4'h0, 16'(prog_len * 4 + 8));
      emit(OP_ST, 4'd9, 4'h0, st_addr);
      st_addr += 2;
      // Load followed right away by its use
      emit(OP_LD, 4'd11, 4'h0, ld_addr);
      s2 = src_reg();
      emit(alu_ops[rand_bits(3) % 5], 4'd12, 4'd11, {s2, 12'h0});
      emit(OP_ST, 4'd12, 4'h0, st_addr);
      st_addr += 2;
    end
    emit(OP_JMP, 4'h0, 4'h0, 16'(prog_len * 4 + 8));
    emit(OP_ST, 4'd10, 4'h0, st_addr);
    st_addr += 2;
    emit(OP_ST, 4'd12, 4'h0, st_addr);
    emit(OP_HLT, 4'h0, 4'h0, 16'h0);
  endtask

  // ========================================
  // Golden ISA model
  // ========================================
  task automatic run_golden();
    logic [15:0] r [16];
    logic        z;
    logic        v;
    logic [31:0] pc;
    logic [31:0] next;
    logic [31:0] ins;
    logic [7:0]  op;
    logic [3:0]  rd;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    logic [15:0] res;
    int          s;
    z  = 1'b0;
    v  = 1'b0;
    pc = '0;
    for (int i = 0; i < 16; i++) r[i] = '0;
    for (int i = 0; i < MEM_WORDS; i++) gmem[i] = mem[i];
    for (int step = 0; step < 400; step++) begin
      ins  = gmem[pc[11:2]];
      op   = ins[31:24];
      rd   = ins[23:20];
      a    = r[ins[19:16]];
      b    = r[ins[15:12]];
      imm  = ins[15:0];
      next = pc + 4;
      if (op == OP_HLT) begin
        hlt_addr = pc;
        break;
      end
      case (op)
        OP_ADD, OP_SUB: begin
          if (op == OP_ADD) s = $signed(a) + $signed(b);
          else s = $signed(a) - $signed(b);
          res   = s[15:0];
          v     = (s > 32767) || (s < -32768);
          z     = (res == 16'h0);
          r[rd] = res;
        end
        OP_AND, OP_OR, OP_XOR: begin
          res   = (op == OP_AND) ? (a & b) : (op == OP_OR) ? (a | b) : (a ^ b);
          v     = 1'b0;
          z     = (res == 16'h0);
          r[rd] = res;
        end
        OP_MOVI: r[rd] = imm;
        // Big-endian halfwords with address bit 1 picking the low half
        OP_LD: r[rd] = imm[1] ? gmem[imm[11:2]][15:0] : gmem[imm[11:2]][31:16];
        OP_ST: begin
          exp_addr.push_back({16'h0, imm});
          exp_data.push_back(r[rd]);
          if (imm[1]) gmem[imm[11:2]][15:0] = r[rd];
          else gmem[imm[11:2]][31:16] = r[rd];
        end
        OP_BEQ: if (z) next = {16'h0, imm};
        OP_BNE: if (!z) next = {16'h0, imm};
        OP_BVS: if (v) next = {16'h0, imm};
        OP_JMP: next = {16'h0, imm};
        default: ;
      endcase
      pc = next;
    end
    n_expected = exp_addr.size();
  endtask

  initial begin
    clk              = 1'b0;
    rst              = 1'b1;
    mem_if_rdata     = '0;
    mem_if_ack       = 1'b0;
    mem_data_rdata   = '0;
    mem_data_ack     = 1'b0;
    lfsr             = 32'h8d6f_1c37;
    prog_len         = 0;
    n_stores         = 0;
    errors           = 0;
    cycles           = 0;
    first_fetch_seen = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    end
    build_program();
    run_golden();
    cycle_limit = 40 * prog_len;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    while (!halted) @(posedge clk);
    assert (current_pc == hlt_addr) else begin
      errors++;
      $display("Fail current_pc: got %h, expected %h", current_pc, hlt_addr);
    end
    assert (n_stores == n_expected) else begin
      errors++;
      $display("Fail store count: got %h, expected %h", n_stores, n_expected);
    end
    // Idle a while so the halt assertions see the stopped core
    repeat (20) @(posedge clk);
    $display("Summary: %0d stores, %0d testbench errors, %0d assertion failures",
             n_stores, errors, UUT.u_sva.fail_count);
    if (errors == 0 && UUT.u_sva.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // ========================================
  // Memory model with a random ack delay per reply
  // ========================================
  always @(posedge clk) begin
    if (rst) begin
      mem_if_ack   <= 1'b0;
      mem_data_ack <= 1'b0;
      if_cnt       <= 0;
      dm_cnt       <= 0;
    end else begin
      if (mem_if_ack || !mem_if_req) begin
        mem_if_ack <= 1'b0;
        if_cnt     <= 0;
      end else begin
        if (if_cnt == 0) if_dly = ack_delay();
        if (if_cnt + 1 >= if_dly) begin
          mem_if_ack   <= 1'b1;
          mem_if_rdata <= mem[mem_if_addr[11:2]];
        end
        if_cnt <= if_cnt + 1;
      end
      if (mem_data_ack || !mem_data_req) begin
        if (mem_data_ack && mem_data_req && mem_data_we) begin
          if (mem_data_addr[1]) mem[mem_data_addr[11:2]][15:0] <= mem_data_wdata;
          else mem[mem_data_addr[11:2]][31:16] <= mem_data_wdata;
        end
        mem_data_ack <= 1'b0;
        dm_cnt       <= 0;
      end else begin
        if (dm_cnt == 0) dm_dly = ack_delay();
        if (dm_cnt + 1 >= dm_dly) begin
          mem_data_ack   <= 1'b1;
          mem_data_rdata <= mem_data_addr[1] ? mem[mem_data_addr[11:2]][15:0]
                                             : mem[mem_data_addr[11:2]][31:16];
        end
        dm_cnt <= dm_cnt + 1;
      end
    end
  end

  // Reset state and first fetch address
  always @(posedge clk) begin
    rst_q <= rst;
    if (rst_q) begin
      assert (!mem_if_req && !mem_data_req && !halted) else begin
        errors++;
        $display("Request or halted high while the core is in reset");
      end
    end
    if (!rst && mem_if_req && !first_fetch_seen) begin
      first_fetch_seen <= 1'b1;
      assert (mem_if_addr == `NEO_RESET_PC) else begin
        errors++;
        $display("Fail mem_if_addr: got %h, expected %h", mem_if_addr, `NEO_RESET_PC);
      end
    end
  end

  // Each completed store against the golden list
  always @(posedge clk) begin
    if (!rst && mem_data_req && mem_data_we && mem_data_ack) begin
      n_stores <= n_stores + 1;
      if (exp_addr.size() == 0) begin
        errors++;
        $display("Store to %h with no store left in the expected list", mem_data_addr);
      end else begin
        assert (mem_data_addr == exp_addr[0]) else begin
          errors++;
          $display("Fail mem_data_addr: got %h, expected %h", mem_data_addr, exp_addr[0]);
        end
        assert (mem_data_wdata == exp_data[0]) else begin
          errors++;
          $display("Fail mem_data_wdata: got %h, expected %h", mem_data_wdata, exp_data[0]);
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit && !halted) begin
      $display("Timeout: halted did not rise within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
neocore_pkg.sv
fetch_unit.sv
decode_unit.sv
execute_stage.sv
memory_stage.sv
core_top.sv
core_top_sva.sv
core_top_tb.sv

// ==== Bender.yml ====
package:
  name: neocore

export_include_dirs:
  - .

sources:
  - files:
      - neocore_pkg.sv
      - fetch_unit.sv
      - decode_unit.sv
      - execute_stage.sv
      - memory_stage.sv
      - core_top.sv
  - target: test
    files:
      - core_top_sva.sv
      - core_top_tb.sv
